/* hdl/host_pkg.sv */
`default_nettype none

package host_pkg;

  // dma read length in words, carried on the host address bus
  typedef logic [31:0] xfer_len_t;

  // one-hot target select
  typedef logic [2:0] target_sel_t;

  // bit positions inside target_sel_t
  localparam int SEL_PER = 0;
  localparam int SEL_MEM = 1;
  localparam int SEL_DMA = 2;

endpackage

`default_nettype wire

/* hdl/ppfifo_pkg.sv */
`default_nettype none

package ppfifo_pkg;

  // one word of a ping-pong buffer
  typedef logic [31:0] word_t;

  // capacity of a single ping-pong buffer in words
  typedef logic [23:0] fifo_size_t;

  // write side ready/activate, one bit per buffer
  typedef logic [1:0] buf_sel_t;

  localparam buf_sel_t NO_BUF = '0;

  // read side sequence of the bridge
  typedef enum logic [1:0] {
    IDLE,
    GRAB,
    STREAM,
    RELEASE
  } bridge_state_t;

endpackage

`default_nettype wire

/* hdl/ppfifo_bridge.sv */
`default_nettype none

module ppfifo_bridge (
  input  wire                          clk,
  input  wire                          rst,

  // read side, this block is the consumer
  input  wire                          i_rd_rdy,
  output logic                         o_rd_act,
  input  wire  ppfifo_pkg::fifo_size_t i_rd_size,
  output logic                         o_rd_stb,
  input  wire  ppfifo_pkg::word_t      i_rd_data,

  // write side, this block is the producer
  input  wire  ppfifo_pkg::buf_sel_t   i_wr_rdy,
  output ppfifo_pkg::buf_sel_t         o_wr_act,
  input  wire  ppfifo_pkg::fifo_size_t i_wr_size,
  output logic                         o_wr_stb,
  output ppfifo_pkg::word_t            o_wr_data,

  output logic                         o_idle
);

  ppfifo_pkg::bridge_state_t state;

  ppfifo_pkg::fifo_size_t rd_size;
  ppfifo_pkg::fifo_size_t rd_count;
  ppfifo_pkg::fifo_size_t wr_size;
  ppfifo_pkg::fifo_size_t wr_count;

  logic wr_held;
  logic wr_want;
  logic move;
  logic rd_last;
  logic wr_last;

  assign wr_held = (o_wr_act != ppfifo_pkg::NO_BUF);

  // a word moves only while both buffers are held
  assign move = (state == ppfifo_pkg::STREAM) && wr_held;

  assign rd_last = move && (rd_count == rd_size - 24'd1);

  // write buffer full, or an empty one was handed over
  assign wr_last = wr_held &&
                   ((wr_size == '0) || (move && (wr_count == wr_size - 24'd1)));

  // only take a write buffer while there is read data to fill it
  assign wr_want = !wr_held && (i_wr_rdy != ppfifo_pkg::NO_BUF) &&
                   ((state == ppfifo_pkg::GRAB) || (state == ppfifo_pkg::STREAM));

  assign o_rd_stb  = move;
  assign o_wr_stb  = move;
  assign o_wr_data = i_rd_data;
  assign o_idle    = !o_rd_act && !wr_held;

  // read side
  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= ppfifo_pkg::IDLE;
      o_rd_act <= 1'b0;
      rd_count <= '0;
    end else begin
      case (state)
        ppfifo_pkg::IDLE: begin
          if (i_rd_rdy) begin
            o_rd_act <= 1'b1;
            state    <= ppfifo_pkg::GRAB;
          end
        end
        ppfifo_pkg::GRAB: begin
          rd_count <= '0;
          // nothing to move in an empty buffer
          if (i_rd_size == '0) begin
            state <= ppfifo_pkg::RELEASE;
          end else begin
            state <= ppfifo_pkg::STREAM;
          end
        end
        ppfifo_pkg::STREAM: begin
          if (move) begin
            rd_count <= rd_count + 24'd1;
          end
          if (rd_last) begin
            state <= ppfifo_pkg::RELEASE;
          end
        end
        default: begin
          o_rd_act <= 1'b0;
          state    <= ppfifo_pkg::IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == ppfifo_pkg::GRAB) begin
      rd_size <= i_rd_size;
    end
  end

  // write side, lowest ready buffer first
  always_ff @(posedge clk) begin
    if (rst) begin
      o_wr_act <= ppfifo_pkg::NO_BUF;
      wr_count <= '0;
    end else if (wr_want) begin
      o_wr_act <= i_wr_rdy[0] ? 2'b01 : 2'b10;
      wr_count <= '0;
    end else if (wr_last || (wr_held && (state == ppfifo_pkg::RELEASE))) begin
      // full, or the read buffer ran out so hand over a partial one
      o_wr_act <= ppfifo_pkg::NO_BUF;
    end else if (move) begin
      wr_count <= wr_count + 24'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_want) begin
      wr_size <= i_wr_size;
    end
  end

endmodule

`default_nettype wire

/* hdl/target_router.sv */
`default_nettype none

module target_router (
  input  wire  host_pkg::target_sel_t  i_sel,
  input  wire                          i_write_flg,
  input  wire                          i_read_flg,

  // host links
  input  wire                          i_pcie_ingress_rdy,
  input  wire  ppfifo_pkg::fifo_size_t i_pcie_ingress_size,
  input  wire  ppfifo_pkg::word_t      i_pcie_ingress_data,
  output logic                         o_pcie_ingress_act,
  output logic                         o_pcie_ingress_stb,
  input  wire  ppfifo_pkg::buf_sel_t   i_pcie_egress_rdy,
  input  wire  ppfifo_pkg::fifo_size_t i_pcie_egress_size,
  output ppfifo_pkg::buf_sel_t         o_pcie_egress_act,
  output logic                         o_pcie_egress_stb,
  output ppfifo_pkg::word_t            o_pcie_egress_data,

  // peripheral links
  output logic                         o_per_ing_rdy,
  output ppfifo_pkg::fifo_size_t       o_per_ing_size,
  output ppfifo_pkg::word_t            o_per_ing_data,
  input  wire                          i_per_ing_act,
  input  wire                          i_per_ing_stb,
  output ppfifo_pkg::buf_sel_t         o_per_egr_rdy,
  output ppfifo_pkg::fifo_size_t       o_per_egr_size,
  input  wire  ppfifo_pkg::buf_sel_t   i_per_egr_act,
  input  wire                          i_per_egr_stb,
  input  wire  ppfifo_pkg::word_t      i_per_egr_data,

  // memory links, facing the bridges
  output logic                         o_mem_ing_rdy,
  output ppfifo_pkg::fifo_size_t       o_mem_ing_size,
  output ppfifo_pkg::word_t            o_mem_ing_data,
  input  wire                          i_mem_ing_act,
  input  wire                          i_mem_ing_stb,
  output ppfifo_pkg::buf_sel_t         o_mem_egr_rdy,
  output ppfifo_pkg::fifo_size_t       o_mem_egr_size,
  input  wire  ppfifo_pkg::buf_sel_t   i_mem_egr_act,
  input  wire                          i_mem_egr_stb,
  input  wire  ppfifo_pkg::word_t      i_mem_egr_data,

  // dma links
  output logic                         o_idma_rdy,
  output ppfifo_pkg::fifo_size_t       o_idma_size,
  output ppfifo_pkg::word_t            o_idma_data,
  input  wire                          i_idma_act,
  input  wire                          i_idma_stb,
  output ppfifo_pkg::buf_sel_t         o_odma_rdy,
  output ppfifo_pkg::fifo_size_t       o_odma_size,
  input  wire  ppfifo_pkg::buf_sel_t   i_odma_act,
  input  wire                          i_odma_stb,
  input  wire  ppfifo_pkg::word_t      i_odma_data,

  // finished flags
  input  wire                          i_per_wr_fin,
  input  wire                          i_per_rd_fin,
  input  wire                          i_mem_fin,
  input  wire                          i_mem_rd_idle,
  input  wire                          i_ingress_idle,
  input  wire                          i_dma_rd_fin,
  output logic                         o_dma_rd_en,
  output logic                         o_write_fin,
  output logic                         o_read_fin
);

  logic wr_per;
  logic wr_mem;
  logic wr_dma;
  logic rd_per;
  logic rd_mem;
  logic rd_dma;

  assign wr_per = i_sel[host_pkg::SEL_PER] & i_write_flg;
  assign wr_mem = i_sel[host_pkg::SEL_MEM] & i_write_flg;
  assign wr_dma = i_sel[host_pkg::SEL_DMA] & i_write_flg;
  assign rd_per = i_sel[host_pkg::SEL_PER] & i_read_flg;
  assign rd_mem = i_sel[host_pkg::SEL_MEM] & i_read_flg;
  assign rd_dma = i_sel[host_pkg::SEL_DMA] & i_read_flg;

  assign o_dma_rd_en = rd_dma;

  // host ingress fans out, unselected targets see zeros
  assign o_per_ing_rdy  = wr_per & i_pcie_ingress_rdy;
  assign o_per_ing_size = wr_per ? i_pcie_ingress_size : '0;
  assign o_per_ing_data = wr_per ? i_pcie_ingress_data : '0;
  assign o_mem_ing_rdy  = wr_mem & i_pcie_ingress_rdy;
  assign o_mem_ing_size = wr_mem ? i_pcie_ingress_size : '0;
  assign o_mem_ing_data = wr_mem ? i_pcie_ingress_data : '0;
  assign o_idma_rdy     = wr_dma & i_pcie_ingress_rdy;
  assign o_idma_size    = wr_dma ? i_pcie_ingress_size : '0;
  assign o_idma_data    = wr_dma ? i_pcie_ingress_data : '0;

  // host egress buffers are offered to the selected source only
  assign o_per_egr_rdy  = rd_per ? i_pcie_egress_rdy : ppfifo_pkg::NO_BUF;
  assign o_per_egr_size = rd_per ? i_pcie_egress_size : '0;
  assign o_mem_egr_rdy  = rd_mem ? i_pcie_egress_rdy : ppfifo_pkg::NO_BUF;
  assign o_mem_egr_size = rd_mem ? i_pcie_egress_size : '0;
  assign o_odma_rdy     = rd_dma ? i_pcie_egress_rdy : ppfifo_pkg::NO_BUF;
  assign o_odma_size    = rd_dma ? i_pcie_egress_size : '0;

  // return paths, peripheral wins if more than one select is set
  always_comb begin
    o_pcie_ingress_act = 1'b0;
    o_pcie_ingress_stb = 1'b0;
    o_write_fin        = 1'b0;
    if (wr_per) begin
      o_pcie_ingress_act = i_per_ing_act;
      o_pcie_ingress_stb = i_per_ing_stb;
      o_write_fin        = i_per_wr_fin;
    end else if (wr_mem) begin
      o_pcie_ingress_act = i_mem_ing_act;
      o_pcie_ingress_stb = i_mem_ing_stb;
      o_write_fin        = i_mem_fin;
    end else if (wr_dma) begin
      o_pcie_ingress_act = i_idma_act;
      o_pcie_ingress_stb = i_idma_stb;
      o_write_fin        = i_ingress_idle;
    end
  end

  always_comb begin
    o_pcie_egress_act  = ppfifo_pkg::NO_BUF;
    o_pcie_egress_stb  = 1'b0;
    o_pcie_egress_data = '0;
    o_read_fin         = 1'b0;
    if (rd_per) begin
      o_pcie_egress_act  = i_per_egr_act;
      o_pcie_egress_stb  = i_per_egr_stb;
      o_pcie_egress_data = i_per_egr_data;
      o_read_fin         = i_per_rd_fin;
    end else if (rd_mem) begin
      o_pcie_egress_act  = i_mem_egr_act;
      o_pcie_egress_stb  = i_mem_egr_stb;
      o_pcie_egress_data = i_mem_egr_data;
      // memory done and the egress bridge has let go of both buffers
      o_read_fin         = i_mem_fin & i_mem_rd_idle;
    end else if (rd_dma) begin
      o_pcie_egress_act  = i_odma_act;
      o_pcie_egress_stb  = i_odma_stb;
      o_pcie_egress_data = i_odma_data;
      o_read_fin         = i_dma_rd_fin;
    end
  end

endmodule

`default_nettype wire

/* hdl/dma_read_tracker.sv */
`default_nettype none

module dma_read_tracker (
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     i_en,
  input  wire  host_pkg::xfer_len_t i_len,
  input  wire                     i_stb,
  output logic                    o_fin
);

  host_pkg::xfer_len_t count;
  host_pkg::xfer_len_t count_next;

  // stop counting once the length is reached
  always_comb begin
    count_next = count;
    if (i_stb && (count < i_len)) begin
      count_next = count + 32'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
      o_fin <= 1'b0;
    end else if (!i_en) begin
      // read over or deselected
      count <= '0;
      o_fin <= 1'b0;
    end else begin
      count <= count_next;
      o_fin <= (count_next >= i_len);
    end
  end

endmodule

`default_nettype wire

/* hdl/pcie_host_router.sv */
`default_nettype none

module pcie_host_router (
  input  wire                          clk,
  input  wire                          rst,

  // transfer control
  input  wire                          i_pcie_per_fifo_sel,
  input  wire                          i_pcie_mem_fifo_sel,
  input  wire                          i_pcie_dma_fifo_sel,
  input  wire                          i_pcie_data_write_flg,
  input  wire                          i_pcie_data_read_flg,
  input  wire  host_pkg::xfer_len_t    i_pcie_data_address,

  // host links
  input  wire                          i_pcie_ingress_rdy,
  output logic                         o_pcie_ingress_act,
  input  wire  ppfifo_pkg::fifo_size_t i_pcie_ingress_size,
  output logic                         o_pcie_ingress_stb,
  input  wire  ppfifo_pkg::word_t      i_pcie_ingress_data,
  input  wire                          i_pcie_ingress_fifo_idle,
  input  wire  ppfifo_pkg::buf_sel_t   i_pcie_egress_rdy,
  output ppfifo_pkg::buf_sel_t         o_pcie_egress_act,
  input  wire  ppfifo_pkg::fifo_size_t i_pcie_egress_size,
  output logic                         o_pcie_egress_stb,
  output ppfifo_pkg::word_t            o_pcie_egress_data,

  // peripheral
  output logic                         o_per_ing_rdy,
  output ppfifo_pkg::fifo_size_t       o_per_ing_size,
  output ppfifo_pkg::word_t            o_per_ing_data,
  input  wire                          i_per_ing_act,
  input  wire                          i_per_ing_stb,
  output ppfifo_pkg::buf_sel_t         o_per_egr_rdy,
  output ppfifo_pkg::fifo_size_t       o_per_egr_size,
  input  wire  ppfifo_pkg::buf_sel_t   i_per_egr_act,
  input  wire                          i_per_egr_stb,
  input  wire  ppfifo_pkg::word_t      i_per_egr_data,
  input  wire                          i_per_wr_fin,
  input  wire                          i_per_rd_fin,

  // dma
  output logic                         o_idma_rdy,
  output ppfifo_pkg::fifo_size_t       o_idma_size,
  output ppfifo_pkg::word_t            o_idma_data,
  input  wire                          i_idma_act,
  input  wire                          i_idma_stb,
  output ppfifo_pkg::buf_sel_t         o_odma_rdy,
  output ppfifo_pkg::fifo_size_t       o_odma_size,
  input  wire  ppfifo_pkg::buf_sel_t   i_odma_act,
  input  wire                          i_odma_stb,
  input  wire  ppfifo_pkg::word_t      i_odma_data,

  // external memory side
  input  wire  ppfifo_pkg::buf_sel_t   i_mem_wr_rdy,
  output ppfifo_pkg::buf_sel_t         o_mem_wr_act,
  input  wire  ppfifo_pkg::fifo_size_t i_mem_wr_size,
  output logic                         o_mem_wr_stb,
  output ppfifo_pkg::word_t            o_mem_wr_data,
  input  wire                          i_mem_rd_rdy,
  output logic                         o_mem_rd_act,
  input  wire  ppfifo_pkg::fifo_size_t i_mem_rd_size,
  output logic                         o_mem_rd_stb,
  input  wire  ppfifo_pkg::word_t      i_mem_rd_data,
  input  wire                          i_mem_fin,

  output logic                         o_pcie_write_fin,
  output logic                         o_pcie_read_fin
);

  host_pkg::target_sel_t  sel;

  // router to memory bridges
  logic                   mem_ing_rdy;
  ppfifo_pkg::fifo_size_t mem_ing_size;
  ppfifo_pkg::word_t      mem_ing_data;
  logic                   mem_ing_act;
  logic                   mem_ing_stb;
  ppfifo_pkg::buf_sel_t   mem_egr_rdy;
  ppfifo_pkg::fifo_size_t mem_egr_size;
  ppfifo_pkg::buf_sel_t   mem_egr_act;
  logic                   mem_egr_stb;
  ppfifo_pkg::word_t      mem_egr_data;

  logic mem_rd_idle;
  logic dma_rd_en;
  logic dma_rd_fin;

  assign sel[host_pkg::SEL_PER] = i_pcie_per_fifo_sel;
  assign sel[host_pkg::SEL_MEM] = i_pcie_mem_fifo_sel;
  assign sel[host_pkg::SEL_DMA] = i_pcie_dma_fifo_sel;

  // host, peripheral and dma ports share names with the router
  target_router u_router (
    .i_sel          (sel),
    .i_write_flg    (i_pcie_data_write_flg),
    .i_read_flg     (i_pcie_data_read_flg),
    .o_mem_ing_rdy  (mem_ing_rdy),
    .o_mem_ing_size (mem_ing_size),
    .o_mem_ing_data (mem_ing_data),
    .i_mem_ing_act  (mem_ing_act),
    .i_mem_ing_stb  (mem_ing_stb),
    .o_mem_egr_rdy  (mem_egr_rdy),
    .o_mem_egr_size (mem_egr_size),
    .i_mem_egr_act  (mem_egr_act),
    .i_mem_egr_stb  (mem_egr_stb),
    .i_mem_egr_data (mem_egr_data),
    .i_mem_rd_idle  (mem_rd_idle),
    .i_ingress_idle (i_pcie_ingress_fifo_idle),
    .i_dma_rd_fin   (dma_rd_fin),
    .o_dma_rd_en    (dma_rd_en),
    .o_write_fin    (o_pcie_write_fin),
    .o_read_fin     (o_pcie_read_fin),
    .*
  );

  // host ingress into external memory
  ppfifo_bridge u_mem_in (
    .clk       (clk),
    .rst       (rst),
    .i_rd_rdy  (mem_ing_rdy),
    .o_rd_act  (mem_ing_act),
    .i_rd_size (mem_ing_size),
    .o_rd_stb  (mem_ing_stb),
    .i_rd_data (mem_ing_data),
    .i_wr_rdy  (i_mem_wr_rdy),
    .o_wr_act  (o_mem_wr_act),
    .i_wr_size (i_mem_wr_size),
    .o_wr_stb  (o_mem_wr_stb),
    .o_wr_data (o_mem_wr_data),
    .o_idle    ()
  );

  // external memory out to host egress
  ppfifo_bridge u_mem_out (
    .clk       (clk),
    .rst       (rst),
    .i_rd_rdy  (i_mem_rd_rdy),
    .o_rd_act  (o_mem_rd_act),
    .i_rd_size (i_mem_rd_size),
    .o_rd_stb  (o_mem_rd_stb),
    .i_rd_data (i_mem_rd_data),
    .i_wr_rdy  (mem_egr_rdy),
    .o_wr_act  (mem_egr_act),
    .i_wr_size (mem_egr_size),
    .o_wr_stb  (mem_egr_stb),
    .o_wr_data (mem_egr_data),
    .o_idle    (mem_rd_idle)
  );

  dma_read_tracker u_dma_trk (
    .clk   (clk),
    .rst   (rst),
    .i_en  (dma_rd_en),
    .i_len (i_pcie_data_address),
    .i_stb (i_odma_stb),
    .o_fin (dma_rd_fin)
  );

endmodule

`default_nettype wire

/* include/tb_checks.svh */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

localparam int WAIT_LIMIT = 400;

int err_count = 0;
logic [31:0] lcg_state = 32'h396d;

// next value of the stimulus sequence
function automatic ppfifo_pkg::word_t lcg_next();
  lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
  return lcg_state;
endfunction

task automatic stop_run(input string why);
  err_count = err_count + 1;
  $display("%s", why);
  $display("CHECKS FAILED");
  $fatal(1, "stopped at first error");
endtask

task automatic value_error(input string what, input logic [31:0] got, input logic [31:0] exp);
  err_count = err_count + 1;
  $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
  $display("CHECKS FAILED");
  $fatal(1, "wrong value");
endtask

task automatic check_word(input ppfifo_pkg::word_t got, input ppfifo_pkg::word_t exp,
                          input string what);
  if (got !== exp) begin
    value_error(what, got, exp);
  end
endtask

task automatic check_size(input ppfifo_pkg::fifo_size_t got,
                          input ppfifo_pkg::fifo_size_t exp, input string what);
  if (got !== exp) begin
    value_error(what, {8'd0, got}, {8'd0, exp});
  end
endtask

task automatic check_bufsel(input ppfifo_pkg::buf_sel_t got,
                            input ppfifo_pkg::buf_sel_t exp, input string what);
  if (got !== exp) begin
    value_error(what, {30'd0, got}, {30'd0, exp});
  end
endtask

task automatic check_flag(input logic got, input logic exp, input string what);
  if (got !== exp) begin
    value_error(what, {31'd0, got}, {31'd0, exp});
  end
endtask

// one cycle of a bounded wait
task automatic wait_step(inout int n, input string what);
  @(posedge clk);
  n = n + 1;
  if (n > WAIT_LIMIT) begin
    stop_run($sformatf("timeout while waiting for %s", what));
  end
endtask

// settle combinational outputs before sampling
task automatic settle();
  @(negedge clk);
endtask

`endif

/* testbench/tb_pcie_host_router.sv */
`default_nettype none

module tb_pcie_host_router;
  timeunit 1ns;
  timeprecision 100ps;

  logic clk = 1'b0;
  logic rst = 1'b1;
  logic i_pcie_per_fifo_sel, i_pcie_mem_fifo_sel, i_pcie_dma_fifo_sel;
  logic i_pcie_data_write_flg, i_pcie_data_read_flg;
  host_pkg::xfer_len_t i_pcie_data_address;
  logic i_pcie_ingress_rdy, o_pcie_ingress_act, o_pcie_ingress_stb, i_pcie_ingress_fifo_idle;
  ppfifo_pkg::fifo_size_t i_pcie_ingress_size, i_pcie_egress_size;
  ppfifo_pkg::word_t i_pcie_ingress_data, o_pcie_egress_data;
  ppfifo_pkg::buf_sel_t i_pcie_egress_rdy, o_pcie_egress_act;
  logic o_pcie_egress_stb;
  logic o_per_ing_rdy, i_per_ing_act, i_per_ing_stb, i_per_egr_stb, i_per_wr_fin, i_per_rd_fin;
  ppfifo_pkg::fifo_size_t o_per_ing_size, o_per_egr_size, o_idma_size, o_odma_size;
  ppfifo_pkg::word_t o_per_ing_data, i_per_egr_data, o_idma_data, i_odma_data;
  ppfifo_pkg::buf_sel_t o_per_egr_rdy, i_per_egr_act, o_odma_rdy, i_odma_act;
  logic o_idma_rdy, i_idma_act, i_idma_stb, i_odma_stb;
  ppfifo_pkg::buf_sel_t i_mem_wr_rdy, o_mem_wr_act;
  ppfifo_pkg::fifo_size_t i_mem_wr_size, i_mem_rd_size;
  ppfifo_pkg::word_t o_mem_wr_data, i_mem_rd_data;
  logic o_mem_wr_stb, i_mem_rd_rdy, o_mem_rd_act, o_mem_rd_stb, i_mem_fin;
  logic o_pcie_write_fin, o_pcie_read_fin;

  // link model state
  ppfifo_pkg::word_t ing_words[$], mrd_words[$], mwr_words[$], egr_words[$];
  ppfifo_pkg::buf_sel_t mwr_acts[$], egr_acts[$];
  int mwr_lens[$], egr_lens[$];
  int ing_idx, mrd_idx, mwr_cnt, egr_cnt;
  logic ing_busy = 1'b0, mrd_busy = 1'b0, mwr_on = 1'b0, egr_on = 1'b0;
  ppfifo_pkg::buf_sel_t mwr_prev = '0, egr_prev = '0;

  `include "tb_checks.svh"

  always #20 clk = ~clk;

  pcie_host_router u_dut (.*);

  // host ingress producer
  always @(posedge clk) begin
    if (ing_busy) begin
      if (o_pcie_ingress_act) i_pcie_ingress_rdy <= 1'b0;
      if (o_pcie_ingress_stb) begin
        ing_idx = ing_idx + 1;
        if (ing_idx < ing_words.size()) i_pcie_ingress_data <= ing_words[ing_idx];
      end
    end
  end

  // memory read-side producer
  always @(posedge clk) begin
    if (mrd_busy) begin
      if (o_mem_rd_act) i_mem_rd_rdy <= 1'b0;
      if (o_mem_rd_stb) begin
        mrd_idx = mrd_idx + 1;
        if (mrd_idx < mrd_words.size()) i_mem_rd_data <= mrd_words[mrd_idx];
      end
    end
  end

  // memory write sink offers a released buffer again
  always @(posedge clk) begin
    if (mwr_on) begin
      if (o_mem_wr_act != ppfifo_pkg::NO_BUF && mwr_prev == ppfifo_pkg::NO_BUF) mwr_cnt = 0;
      if (o_mem_wr_stb) begin
        mwr_words.push_back(o_mem_wr_data);
        mwr_cnt = mwr_cnt + 1;
      end
      if (o_mem_wr_act != ppfifo_pkg::NO_BUF) begin
        i_mem_wr_rdy <= i_mem_wr_rdy & ~o_mem_wr_act;
      end else if (mwr_prev != ppfifo_pkg::NO_BUF) begin
        mwr_acts.push_back(mwr_prev);
        mwr_lens.push_back(mwr_cnt);
        i_mem_wr_rdy <= i_mem_wr_rdy | mwr_prev;
      end
      mwr_prev = o_mem_wr_act;
    end
  end

  // host egress sink
  always @(posedge clk) begin
    if (egr_on) begin
      if (o_pcie_egress_act != ppfifo_pkg::NO_BUF && egr_prev == ppfifo_pkg::NO_BUF) egr_cnt = 0;
      if (o_pcie_egress_stb) begin
        egr_words.push_back(o_pcie_egress_data);
        egr_cnt = egr_cnt + 1;
      end
      if (o_pcie_egress_act != ppfifo_pkg::NO_BUF) begin
        i_pcie_egress_rdy <= i_pcie_egress_rdy & ~o_pcie_egress_act;
      end else if (egr_prev != ppfifo_pkg::NO_BUF) begin
        egr_acts.push_back(egr_prev);
        egr_lens.push_back(egr_cnt);
        i_pcie_egress_rdy <= i_pcie_egress_rdy | egr_prev;
      end
      egr_prev = o_pcie_egress_act;
    end
  end

  task automatic clear_control();
    @(posedge clk);
    i_pcie_per_fifo_sel <= 1'b0;
    i_pcie_mem_fifo_sel <= 1'b0;
    i_pcie_dma_fifo_sel <= 1'b0;
    i_pcie_data_write_flg <= 1'b0;
    i_pcie_data_read_flg <= 1'b0;
  endtask

  task automatic check_quiet(input string tag);
    settle();
    check_flag(o_pcie_ingress_act, 1'b0, {tag, " ingress act"});
    check_flag(o_pcie_ingress_stb, 1'b0, {tag, " ingress stb"});
    check_bufsel(o_pcie_egress_act, ppfifo_pkg::NO_BUF, {tag, " egress act"});
    check_flag(o_pcie_egress_stb, 1'b0, {tag, " egress stb"});
    check_flag(o_per_ing_rdy, 1'b0, {tag, " per ing rdy"});
    check_bufsel(o_per_egr_rdy, ppfifo_pkg::NO_BUF, {tag, " per egr rdy"});
    check_flag(o_idma_rdy, 1'b0, {tag, " idma rdy"});
    check_bufsel(o_odma_rdy, ppfifo_pkg::NO_BUF, {tag, " odma rdy"});
    check_flag(o_pcie_write_fin, 1'b0, {tag, " write fin"});
    check_flag(o_pcie_read_fin, 1'b0, {tag, " read fin"});
    check_bufsel(o_mem_wr_act, ppfifo_pkg::NO_BUF, {tag, " mem wr act"});
  endtask

  task automatic idle_routing();
    @(posedge clk);
    i_pcie_ingress_rdy <= 1'b1;
    i_pcie_egress_rdy <= 2'b11;
    i_per_ing_act <= 1'b1;
    i_per_ing_stb <= 1'b1;
    i_per_egr_act <= 2'b11;
    i_per_egr_stb <= 1'b1;
    i_idma_stb <= 1'b1;
    i_odma_act <= 2'b11;
    i_per_wr_fin <= 1'b1;
    i_per_rd_fin <= 1'b1;
    i_mem_fin <= 1'b1;
    i_pcie_ingress_fifo_idle <= 1'b1;
    check_quiet("no select");
    @(posedge clk);
    i_pcie_per_fifo_sel <= 1'b1;
    check_quiet("no flag");
    clear_control();
    i_pcie_ingress_rdy <= 1'b0;
    i_pcie_egress_rdy <= 2'b00;
    i_per_ing_act <= 1'b0;
    i_per_ing_stb <= 1'b0;
    i_per_egr_act <= 2'b00;
    i_per_egr_stb <= 1'b0;
    i_idma_stb <= 1'b0;
    i_odma_act <= 2'b00;
    i_per_wr_fin <= 1'b0;
    i_per_rd_fin <= 1'b0;
    i_mem_fin <= 1'b0;
    i_pcie_ingress_fifo_idle <= 1'b0;
  endtask

  task automatic peripheral_passthrough();
    ppfifo_pkg::word_t w;
    w = lcg_next();
    @(posedge clk);
    i_pcie_per_fifo_sel <= 1'b1;
    i_pcie_data_write_flg <= 1'b1;
    i_pcie_ingress_rdy <= 1'b1;
    i_pcie_ingress_size <= 24'h11;
    i_pcie_ingress_data <= w;
    i_per_ing_act <= 1'b1;
    i_per_ing_stb <= 1'b1;
    settle();
    check_flag(o_per_ing_rdy, 1'b1, "per ing rdy");
    check_size(o_per_ing_size, 24'h11, "per ing size");
    check_word(o_per_ing_data, w, "per ing data");
    check_flag(o_pcie_ingress_act, 1'b1, "host ingress act");
    check_flag(o_pcie_ingress_stb, 1'b1, "host ingress stb");
    check_flag(o_pcie_write_fin, 1'b0, "per write fin low");
    @(posedge clk);
    i_per_wr_fin <= 1'b1;
    settle();
    check_flag(o_pcie_write_fin, 1'b1, "per write fin high");
    @(posedge clk);
    i_per_wr_fin <= 1'b0;
    i_per_ing_act <= 1'b0;
    i_per_ing_stb <= 1'b0;
    i_pcie_data_write_flg <= 1'b0;
    i_pcie_data_read_flg <= 1'b1;
    i_pcie_egress_rdy <= 2'b10;
    i_pcie_egress_size <= 24'h20;
    i_per_egr_act <= 2'b01;
    i_per_egr_stb <= 1'b1;
    w = lcg_next();
    i_per_egr_data <= w;
    settle();
    check_flag(o_pcie_write_fin, 1'b0, "write fin after write");
    check_bufsel(o_per_egr_rdy, 2'b10, "per egr rdy");
    check_size(o_per_egr_size, 24'h20, "per egr size");
    check_bufsel(o_pcie_egress_act, 2'b01, "host egress act");
    check_flag(o_pcie_egress_stb, 1'b1, "host egress stb");
    check_word(o_pcie_egress_data, w, "host egress data");
    check_flag(o_pcie_read_fin, 1'b0, "per read fin low");
    @(posedge clk);
    i_per_rd_fin <= 1'b1;
    settle();
    check_flag(o_pcie_read_fin, 1'b1, "per read fin high");
    clear_control();
    i_pcie_ingress_rdy <= 1'b0;
    i_pcie_egress_rdy <= 2'b00;
    i_per_egr_act <= 2'b00;
    i_per_egr_stb <= 1'b0;
    i_per_rd_fin <= 1'b0;
  endtask

  task automatic memory_write();
    int n;
    for (int k = 0; k < 7; k++) ing_words.push_back(lcg_next());
    @(posedge clk);
    i_pcie_mem_fifo_sel <= 1'b1;
    i_pcie_data_write_flg <= 1'b1;
    i_mem_wr_size <= 24'd4;
    i_mem_wr_rdy <= 2'b11;
    mwr_on = 1'b1;
    ing_idx = 0;
    ing_busy = 1'b1;
    i_pcie_ingress_rdy <= 1'b1;
    i_pcie_ingress_size <= 24'd7;
    i_pcie_ingress_data <= ing_words[0];
    n = 0;
    while (mwr_lens.size() < 2) wait_step(n, "memory write buffers");
    n = 0;
    while (o_pcie_ingress_act) wait_step(n, "host ingress release");
    if (mwr_words.size() != 7) stop_run("memory write word count is wrong");
    for (int k = 0; k < 7; k++) check_word(mwr_words[k], ing_words[k], "memory write word");
    check_bufsel(mwr_acts[0], 2'b01, "first memory buffer");
    check_bufsel(mwr_acts[1], 2'b10, "second memory buffer");
    check_word(mwr_lens[0], 32'd4, "first buffer length");
    check_word(mwr_lens[1], 32'd3, "second buffer length");
    @(posedge clk);
    i_mem_fin <= 1'b1;
    settle();
    check_flag(o_pcie_write_fin, 1'b1, "memory write fin high");
    @(posedge clk);
    i_mem_fin <= 1'b0;
    settle();
    check_flag(o_pcie_write_fin, 1'b0, "memory write fin low");
    ing_busy = 1'b0;
    mwr_on = 1'b0;
    clear_control();
    i_mem_wr_rdy <= 2'b00;
  endtask

  task automatic memory_read();
    int n;
    for (int k = 0; k < 6; k++) mrd_words.push_back(lcg_next());
    @(posedge clk);
    i_pcie_mem_fifo_sel <= 1'b1;
    i_pcie_data_read_flg <= 1'b1;
    i_pcie_egress_size <= 24'd8;
    i_pcie_egress_rdy <= 2'b11;
    i_mem_fin <= 1'b1;
    egr_on = 1'b1;
    mrd_idx = 0;
    mrd_busy = 1'b1;
    i_mem_rd_rdy <= 1'b1;
    i_mem_rd_size <= 24'd6;
    i_mem_rd_data <= mrd_words[0];
    n = 0;
    while (!o_mem_rd_act) wait_step(n, "memory read grab");
    settle();
    check_flag(o_pcie_read_fin, 1'b0, "read fin while bridge busy");
    n = 0;
    while (!o_pcie_read_fin) wait_step(n, "memory read fin");
    settle();
    check_flag(o_mem_rd_act, 1'b0, "memory read act released");
    check_bufsel(o_pcie_egress_act, ppfifo_pkg::NO_BUF, "egress act released");
    if (egr_words.size() != 6) stop_run("host egress word count is wrong");
    for (int k = 0; k < 6; k++) check_word(egr_words[k], mrd_words[k], "host egress word");
    @(posedge clk);
    i_mem_fin <= 1'b0;
    settle();
    check_flag(o_pcie_read_fin, 1'b0, "read fin after mem fin drops");
    // six words fit one egress buffer, released partly filled
    if (egr_lens.size() != 1) stop_run("host egress buffer count is wrong");
    check_bufsel(egr_acts[0], 2'b01, "host egress buffer");
    check_word(egr_lens[0], 32'd6, "host egress buffer length");
    mrd_busy = 1'b0;
    egr_on = 1'b0;
    clear_control();
    i_pcie_egress_rdy <= 2'b00;
  endtask

  task automatic dma_read_completion();
    ppfifo_pkg::word_t w;
    w = lcg_next();
    @(posedge clk);
    i_pcie_dma_fifo_sel <= 1'b1;
    i_pcie_data_read_flg <= 1'b1;
    i_pcie_data_address <= 32'd5;
    i_pcie_egress_rdy <= 2'b01;
    i_pcie_egress_size <= 24'd5;
    i_odma_act <= 2'b01;
    i_odma_data <= w;
    settle();
    check_bufsel(o_odma_rdy, 2'b01, "odma rdy");
    check_size(o_odma_size, 24'd5, "odma size");
    check_bufsel(o_pcie_egress_act, 2'b01, "dma egress act");
    check_word(o_pcie_egress_data, w, "dma egress data");
    for (int k = 1; k <= 5; k++) begin
      @(posedge clk);
      i_odma_stb <= 1'b1;
      settle();
      check_flag(o_pcie_egress_stb, 1'b1, "dma strobe routed");
      @(posedge clk);
      i_odma_stb <= 1'b0;
      settle();
      check_flag(o_pcie_read_fin, k == 5, $sformatf("dma read fin after strobe %0d", k));
    end
    @(posedge clk);
    i_pcie_data_read_flg <= 1'b0;
    i_odma_act <= 2'b00;
    settle();
    check_flag(o_pcie_read_fin, 1'b0, "dma read fin after flag drop");
    // tracker must have cleared while the flag was low
    @(posedge clk);
    i_pcie_data_read_flg <= 1'b1;
    settle();
    check_flag(o_pcie_read_fin, 1'b0, "dma read fin cleared after flag drop");
    @(posedge clk);
    i_pcie_data_read_flg <= 1'b0;
    i_pcie_data_write_flg <= 1'b1;
    i_pcie_ingress_fifo_idle <= 1'b1;
    i_pcie_ingress_rdy <= 1'b1;
    i_pcie_ingress_size <= 24'd9;
    i_pcie_ingress_data <= w;
    i_idma_act <= 1'b1;
    settle();
    check_flag(o_pcie_write_fin, 1'b1, "dma write fin high");
    check_flag(o_idma_rdy, 1'b1, "idma rdy");
    check_size(o_idma_size, 24'd9, "idma size");
    check_word(o_idma_data, w, "idma data");
    check_flag(o_pcie_ingress_act, 1'b1, "dma ingress act");
    @(posedge clk);
    i_pcie_ingress_fifo_idle <= 1'b0;
    settle();
    check_flag(o_pcie_write_fin, 1'b0, "dma write fin low");
    clear_control();
    i_pcie_ingress_rdy <= 1'b0;
    i_pcie_egress_rdy <= 2'b00;
    i_idma_act <= 1'b0;
  endtask

  initial begin
    {i_pcie_per_fifo_sel, i_pcie_mem_fifo_sel, i_pcie_dma_fifo_sel} = 3'b000;
    {i_pcie_data_write_flg, i_pcie_data_read_flg} = 2'b00;
    i_pcie_data_address = '0;
    {i_pcie_ingress_rdy, i_pcie_ingress_fifo_idle, i_mem_fin} = 3'b000;
    i_pcie_ingress_size = '0;
    i_pcie_ingress_data = '0;
    i_pcie_egress_rdy = '0;
    i_pcie_egress_size = '0;
    {i_per_ing_act, i_per_ing_stb, i_per_egr_stb, i_per_wr_fin, i_per_rd_fin} = 5'b00000;
    i_per_egr_act = '0;
    i_per_egr_data = '0;
    {i_idma_act, i_idma_stb, i_odma_stb} = 3'b000;
    i_odma_act = '0;
    i_odma_data = '0;
    i_mem_wr_rdy = '0;
    i_mem_wr_size = '0;
    i_mem_rd_rdy = 1'b0;
    i_mem_rd_size = '0;
    i_mem_rd_data = '0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    idle_routing();
    peripheral_passthrough();
    memory_write();
    memory_read();
    dma_read_completion();
    if (err_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
+incdir+include
hdl/host_pkg.sv
hdl/ppfifo_pkg.sv
hdl/ppfifo_bridge.sv
hdl/target_router.sv
hdl/dma_read_tracker.sv
hdl/pcie_host_router.sv
testbench/tb_pcie_host_router.sv

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with Verilator, pass only on the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/100ps -f src.f \
  --top-module tb_pcie_host_router -o tb_sim || { echo "build failed"; exit 1; }
out=$(./obj_dir/tb_sim)
echo "$out"
echo "$out" | grep -q "ALL CHECKS PASSED" && echo "simulation passed" || {
  echo "simulation failed"
  exit 1
}
